// ==== Bender.yml ====
package:
  name: fetch_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/icache_pkg.sv
      - src/fetch_line_if.sv
      - src/icache_way.sv
      - src/icache.sv
      - src/fetch_queue.sv
      - src/inst_aligner.sv
      - src/fetch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/fetch_checker.sv
      - sim/tb_fetch_top.sv

// ==== compile.f ====
+incdir+include
src/icache_pkg.sv
src/fetch_line_if.sv
src/icache_way.sv
src/icache.sv
src/fetch_queue.sv
src/inst_aligner.sv
src/fetch_top.sv
sim/fetch_checker.sv
sim/tb_fetch_top.sv

// ==== include/icache_settings.svh ====
// line size is fixed at 16 bytes (four words); replacement assumes exactly 2 ways; queue depth >= 3
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ============================================================
// address and cache geometry
// ============================================================
`define ICACHE_ADDR_W      32   // physical address
`define ICACHE_LINE_BYTES  16   // four 32-bit words
`define ICACHE_SETS        16
`define ICACHE_WAYS        2    // round-robin bit per set

// ============================================================
// fetch queue
// ============================================================
// three slots are held back for lookups in S1, S2 and the next request
`define FETCH_QUEUE_DEPTH  4

`endif

// ==== sim/fetch_checker.sv ====
// scoreboard for fetch_top; samples at the falling edge, fence is only expected while the cache is idle
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module fetch_checker (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_req_valid,
  input  logic [`ICACHE_ADDR_W-1:0] i_req_addr,
  input  logic                      i_req_ready,
  input  logic                      i_inst_valid,
  input  logic [31:0]               i_inst,
  input  logic [`ICACHE_ADDR_W-1:0] i_inst_addr,
  input  logic                      i_inst_ready,
  input  logic                      i_flush,
  input  logic                      i_fence_i,
  input  logic [`ICACHE_ADDR_W-1:0] i_araddr,
  input  logic                      i_arvalid,
  input  logic                      i_arready,
  input  logic [2:0]                i_arprot,
  input  logic                      i_rvalid,
  input  logic                      i_rready,
  output int                        o_errors,
  output int                        o_checks,
  output int                        o_pending_inst,
  output int                        o_pending_ar,
  output int                        o_ar_count
);

  localparam int OFF_W = $clog2(`ICACHE_LINE_BYTES);
  localparam int SET_W = $clog2(`ICACHE_SETS);
  localparam int TAG_W = `ICACHE_ADDR_W - SET_W - OFF_W;

  logic [TAG_W-1:0]            tags [`ICACHE_WAYS][`ICACHE_SETS];
  bit                          tag_ok [`ICACHE_WAYS][`ICACHE_SETS];
  bit [`ICACHE_SETS-1:0]       repl;               // way to fill next, per set
  logic [`ICACHE_ADDR_W+31:0]  exp_inst [$];       // {addr, word}
  logic [`ICACHE_ADDR_W-1:0]   exp_ar [$];
  logic [`ICACHE_ADDR_W+31:0]  exp_entry;
  logic [`ICACHE_ADDR_W-1:0]   exp_addr;
  bit                          s1_busy;            // request accepted last cycle
  logic [`ICACHE_ADDR_W-1:0]   s1_addr;

  // memory contents: address xor a pattern, rotated by 8 bits per word index
  function automatic logic [31:0] ref_word(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [31:0] x;
    x = addr[31:0] ^ 32'hA5C3_0F96;
    return (x << (8 * addr[3:2])) | (x >> (32 - 8 * addr[3:2]));
  endfunction

  task automatic clear_tags();
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        tag_ok[w][s] = 1'b0;
      end
    end
  endtask

  // lookup as it leaves S1; a miss fills the round-robin way and expects four reads
  task automatic lookup(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [SET_W-1:0] set;
    logic [TAG_W-1:0] tag;
    bit               hit;
    int               way;
    set = addr[OFF_W +: SET_W];
    tag = addr[`ICACHE_ADDR_W-1 -: TAG_W];
    hit = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (tag_ok[w][set] && tags[w][set] == tag) hit = 1'b1;
    end
    if (!hit) begin
      way = repl[set];
      tags[way][set]   = tag;
      tag_ok[way][set] = 1'b1;
      repl[set]        = !repl[set];
      for (int b = 0; b < 4; b++) begin
        exp_ar.push_back({addr[`ICACHE_ADDR_W-1:OFF_W], 2'(b), 2'b00});
      end
    end
  endtask

  // ============================================================
  // compare on every transfer of the cycle
  // ============================================================
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      clear_tags();
      repl    = '0;
      s1_busy = 1'b0;
      exp_inst.delete();
      exp_ar.delete();
    end else begin
      if (i_inst_valid && i_inst_ready) begin
        o_checks++;
        if (exp_inst.size() == 0) begin
          $display("ERROR %0t: instruction %h at %h with none expected", $time, i_inst, i_inst_addr);
          o_errors++;
        end else begin
          exp_entry = exp_inst.pop_front();
          if ({i_inst_addr, i_inst} !== exp_entry) begin
            $display("ERROR %0t: instruction %h at %h, expected %h at %h", $time, i_inst,
                     i_inst_addr, exp_entry[31:0], exp_entry[`ICACHE_ADDR_W+31:32]);
            o_errors++;
          end
        end
      end
      if (i_arvalid && i_arready) begin
        o_checks++;
        o_ar_count++;
        if (exp_ar.size() == 0) begin
          $display("ERROR %0t: AR read of %h with no refill expected", $time, i_araddr);
          o_errors++;
        end else begin
          exp_addr = exp_ar.pop_front();
          if (i_araddr !== exp_addr) begin
            $display("ERROR %0t: AR address %h, expected %h", $time, i_araddr, exp_addr);
            o_errors++;
          end
        end
        if (i_arprot[2] !== 1'b1) begin   // AXI prot bit 2 marks an instruction access
          $display("ERROR %0t: AR prot %b is not an instruction access", $time, i_arprot);
          o_errors++;
        end
      end
      if (i_rvalid) begin
        o_checks++;
        if (i_rready !== 1'b1) begin
          $display("ERROR %0t: R beat offered while rready is low", $time);
          o_errors++;
        end
      end
      if (s1_busy && !i_flush) lookup(s1_addr);   // flush kills the S1 lookup
      s1_busy = 1'b0;
      if (i_flush) exp_inst.delete();
      if (i_fence_i) clear_tags();
      if (i_req_valid && i_req_ready) begin
        for (int w = i_req_addr[OFF_W-1:2]; w < 4; w++) begin
          exp_addr = {i_req_addr[`ICACHE_ADDR_W-1:OFF_W], 2'(w), 2'b00};
          exp_inst.push_back({exp_addr, ref_word(exp_addr)});
        end
        s1_busy = 1'b1;
        s1_addr = i_req_addr;
      end
    end
    o_pending_inst = exp_inst.size();
    o_pending_ar   = exp_ar.size();
  end

endmodule

`default_nettype wire

// ==== sim/tb_fetch_top.sv ====
// testbench for fetch_top; AXI memory with LFSR waits, requests held until accepted, cycle limit
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tb_fetch_top;

  localparam int REQS_COLD   = 6;
  localparam int REQS_REPEAT = 6;
  localparam int REQS_EVICT  = 6;
  localparam int REQS_STALL  = 8;
  localparam int REQS_FENCE  = 8;
  localparam int REQS_FLUSH  = 8;
  localparam int TIMEOUT_CYCLES = 40 * (REQS_COLD + REQS_REPEAT + REQS_EVICT + REQS_STALL
                                  + REQS_FENCE + REQS_FLUSH) + 200;

  logic                      clk = 1'b0;
  logic                      reset_n;
  logic                      req_valid;
  logic [`ICACHE_ADDR_W-1:0] req_addr;
  logic                      req_ready;
  logic                      inst_valid;
  logic [31:0]               inst;
  logic [`ICACHE_ADDR_W-1:0] inst_addr;
  logic                      inst_ready;
  logic                      flush;
  logic                      fence_i;
  logic [`ICACHE_ADDR_W-1:0] araddr;
  logic                      arvalid;
  logic                      arready;
  logic [31:0]               rdata;
  logic                      rvalid;
  logic                      rready;
  logic [2:0]                arprot;

  int          chk_errors;
  int          chk_checks;
  int          pending_inst;
  int          pending_ar;
  int          ar_count;
  logic [15:0] lfsr = 16'd17533;
  bit          random_ready;
  int          cycle_count;
  int          tb_errors;
  int          tests_run;
  int          tests_failed;
  int          err_base;
  int          ar_base;

  fetch_top fetch_top_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_req_valid  (req_valid),
    .i_req_addr   (req_addr),
    .o_req_ready  (req_ready),
    .o_inst_valid (inst_valid),
    .o_inst       (inst),
    .o_inst_addr  (inst_addr),
    .i_inst_ready (inst_ready),
    .i_flush      (flush),
    .i_fence_i    (fence_i),
    .o_araddr     (araddr),
    .o_arvalid    (arvalid),
    .i_arready    (arready),
    .i_rdata      (rdata),
    .i_rvalid     (rvalid),
    .o_rready     (rready),
    .o_arprot     (arprot)
  );

  fetch_checker fetch_checker_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_req_valid    (req_valid),
    .i_req_addr     (req_addr),
    .i_req_ready    (req_ready),
    .i_inst_valid   (inst_valid),
    .i_inst         (inst),
    .i_inst_addr    (inst_addr),
    .i_inst_ready   (inst_ready),
    .i_flush        (flush),
    .i_fence_i      (fence_i),
    .i_araddr       (araddr),
    .i_arvalid      (arvalid),
    .i_arready      (arready),
    .i_arprot       (arprot),
    .i_rvalid       (rvalid),
    .i_rready       (rready),
    .o_errors       (chk_errors),
    .o_checks       (chk_checks),
    .o_pending_inst (pending_inst),
    .o_pending_ar   (pending_ar),
    .o_ar_count     (ar_count)
  );

  always #50 clk = ~clk;

  // fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    logic        fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = (v << 1) | fb;
    end
    return v;
  endfunction

  function automatic logic [31:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [31:0] x;
    x = addr[31:0] ^ 32'hA5C3_0F96;
    return (x << (8 * addr[3:2])) | (x >> (32 - 8 * addr[3:2]));
  endfunction

  // ============================================================
  // AXI4-Lite read slave, one beat per address
  // ============================================================
  initial begin : axi_memory
    int unsigned                gap;
    logic [`ICACHE_ADDR_W-1:0] rd_addr;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    @(posedge clk);
    #1;
    forever begin
      if (arvalid !== 1'b1) begin
        @(posedge clk);
        #1;
      end else begin
        gap = take_bits(2);
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        rd_addr = araddr;
        arready = 1'b1;
        @(posedge clk);
        #1;
        arready = 1'b0;
        gap = take_bits(2);
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        rdata  = mem_word(rd_addr);
        rvalid = 1'b1;
        @(posedge clk);
        #1;
        rvalid = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    inst_ready = random_ready ? (take_bits(2) != 0) : 1'b1;   // 3 in 4 when random
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles: %0d instructions and %0d AR reads never arrived",
               cycle_count, pending_inst, pending_ar);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ============================================================
  // stimulus tasks, entered and left 1 ns after a rising edge
  // ============================================================
  task automatic send_req(input logic [`ICACHE_ADDR_W-1:0] addr);
    req_valid = 1'b1;
    req_addr  = addr;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle();
    req_valid = 1'b0;
    while (pending_inst != 0 || pending_ar != 0 || !req_ready) begin
      @(posedge clk);
      #1;
    end
  endtask

  // one-cycle flush or fence
  task automatic pulse_control(input bit is_flush);
    req_valid = 1'b0;
    if (is_flush) begin
      flush = 1'b1;
    end else begin
      fence_i = 1'b1;
    end
    @(posedge clk);
    #1;
    flush   = 1'b0;
    fence_i = 1'b0;
  endtask

  task automatic end_test(input string name, input int exp_ar);
    int new_errs;
    int ar_reads;
    wait_idle();
    ar_reads = ar_count - ar_base;
    if (exp_ar >= 0 && ar_reads != exp_ar) begin
      $display("ERROR %0t: %0d AR reads, expected %0d", $time, ar_reads, exp_ar);
      tb_errors++;
    end
    new_errs = chk_errors + tb_errors - err_base;
    tests_run++;
    if (new_errs != 0) tests_failed++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (new_errs == 0) ? "passed" : "failed", new_errs);
    err_base = chk_errors + tb_errors;
    ar_base  = ar_count;
  endtask

  initial begin : stimulus
    reset_n    = 1'b0;
    req_valid  = 1'b0;
    req_addr   = '0;
    inst_ready = 1'b1;
    flush      = 1'b0;
    fence_i    = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    #1;

    for (int i = 0; i < REQS_COLD; i++) begin
      send_req(32'h1000 + 32'(16 * i + 4 * (i % 4)));   // some start mid-line
    end
    end_test("cold sequential fetch", 4 * REQS_COLD);

    for (int i = 0; i < REQS_REPEAT; i++) begin
      send_req(32'h1000 + 32'(16 * i + 4 * (i % 4)));
    end
    end_test("cached refetch", 0);

    send_req(32'h2040);   // all in set 4
    send_req(32'h3040);
    send_req(32'h4040);
    send_req(32'h2040);
    send_req(32'h4040);
    send_req(32'h3040);
    end_test("round-robin eviction", 20);

    random_ready = 1'b1;
    for (int i = 0; i < REQS_STALL; i++) begin
      send_req(32'h1000 + 32'(16 * (i % 6) + 4 * ((3 * i) % 4)));
    end
    end_test("random back-pressure", -1);
    random_ready = 1'b0;

    for (int i = 0; i < REQS_FENCE / 2; i++) begin
      send_req(32'h1000 + 32'(16 * i));
    end
    wait_idle();
    pulse_control(1'b0);
    ar_base = ar_count;
    for (int i = 0; i < REQS_FENCE / 2; i++) begin
      send_req(32'h1000 + 32'(16 * i));
    end
    end_test("fence then refetch", 4 * (REQS_FENCE / 2));

    random_ready = 1'b1;
    send_req(32'h5000);
    send_req(32'h5010);
    send_req(32'h1000);
    send_req(32'h5020);
    req_valid = 1'b0;
    repeat (3) begin   // lets the last miss start its refill
      @(posedge clk);
      #1;
    end
    pulse_control(1'b1);
    send_req(32'h5024);
    send_req(32'h5030);
    send_req(32'h1014);
    send_req(32'h6008);
    end_test("flush mid-stream", -1);
    random_ready = 1'b0;

    $display("tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             chk_checks, chk_errors + tb_errors);
    if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/fetch_line_if.sv ====
// line transfer on valid and ready both high; payload must be held stable while valid waits
`timescale 1ns/1ps
`default_nettype none

interface fetch_line_if;
  import icache_pkg::*;

  logic       valid;
  logic       ready;
  line_base_t base;
  word_idx_t  start;
  line_data_t data;

  modport source (
    output valid,
    output base,
    output start,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  base,
    input  start,
    input  data,
    output ready
  );

  modport monitor (input valid, input ready, input base, input start, input data);

endinterface

`default_nettype wire

// ==== src/fetch_queue.sv ====
// line FIFO; push ready keeps three slots spare, which covers two lookups in flight plus one new
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module fetch_queue #(
  parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  logic         i_flush,
  fetch_line_if.sink   i_push,
  fetch_line_if.source o_pop
);
  import icache_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  fetch_line_t      r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             w_push;
  logic             w_pop;

  assign w_push = i_push.valid;   // room was reserved when the lookup started
  assign w_pop  = o_pop.valid && o_pop.ready && !i_flush;

  assign i_push.ready = (r_count <= CNT_W'(DEPTH - 3));
  assign o_pop.valid  = (r_count != '0);
  assign o_pop.base   = r_mem[r_rd_ptr].base;
  assign o_pop.start  = r_mem[r_rd_ptr].start;
  assign o_pop.data   = r_mem[r_rd_ptr].data;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      r_count <= r_count + CNT_W'(w_push) - CNT_W'(w_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_mem[r_wr_ptr] <= '{base: i_push.base, start: i_push.start, data: i_push.data};
    end
  end

  // cache only launches lookups with room reserved
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_push.valid |-> (r_count < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
// fetch subsystem top; read-only AXI4-Lite master, addresses are physical, RRESP is not checked
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module fetch_top (
  input  logic              i_clk,
  input  logic              i_reset_n,
  // fetch request
  input  logic              i_req_valid,
  input  icache_pkg::addr_t i_req_addr,
  output logic              o_req_ready,
  // instruction out
  output logic              o_inst_valid,
  output logic [31:0]       o_inst,
  output icache_pkg::addr_t o_inst_addr,
  input  logic              i_inst_ready,
  input  logic              i_flush,
  input  logic              i_fence_i,
  // AXI4-Lite read
  output icache_pkg::addr_t o_araddr,
  output logic              o_arvalid,
  input  logic              i_arready,
  input  logic [31:0]       i_rdata,
  input  logic              i_rvalid,
  output logic              o_rready,
  output logic [2:0]        o_arprot
);

  fetch_line_if push_if ();   // cache to queue
  fetch_line_if pop_if ();    // queue to aligner

  icache icache_i (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req_valid (i_req_valid),
    .i_req_addr  (i_req_addr),
    .o_req_ready (o_req_ready),
    .i_flush     (i_flush),
    .i_fence_i   (i_fence_i),
    .o_araddr    (o_araddr),
    .o_arvalid   (o_arvalid),
    .i_arready   (i_arready),
    .i_rdata     (i_rdata),
    .i_rvalid    (i_rvalid),
    .o_rready    (o_rready),
    .o_arprot    (o_arprot),
    .o_line      (push_if.source)
  );

  fetch_queue #(.DEPTH(`FETCH_QUEUE_DEPTH)) fetch_queue_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_push    (push_if.sink),
    .o_pop     (pop_if.source)
  );

  inst_aligner inst_aligner_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_line       (pop_if.sink),
    .o_inst_valid (o_inst_valid),
    .o_inst       (o_inst),
    .o_inst_addr  (o_inst_addr),
    .i_inst_ready (i_inst_ready)
  );

endmodule

`default_nettype wire

// ==== src/icache.sv ====
// 2-way icache, 16-byte lines refilled by four single AXI4-Lite reads; push side must never be full
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_req_valid,
  input  icache_pkg::addr_t  i_req_addr,
  output logic               o_req_ready,
  input  logic               i_flush,
  input  logic               i_fence_i,
  output icache_pkg::addr_t  o_araddr,
  output logic               o_arvalid,
  input  logic               i_arready,
  input  logic [31:0]        i_rdata,
  input  logic               i_rvalid,
  output logic               o_rready,
  output logic [2:0]         o_arprot,
  fetch_line_if.source       o_line
);
  import icache_pkg::*;

  localparam int OFF_W = $clog2(`ICACHE_LINE_BYTES);
  localparam int WAYS  = `ICACHE_WAYS;

  icache_state_t r_state;
  logic          r_run;          // low through reset
  logic          r_fence_pend;
  logic          w_clear;

  logic          w_accept;
  logic          w_replay;
  logic          w_s0_valid;
  addr_t         w_s0_addr;

  logic          r_s1_valid;
  addr_t         r_s1_addr;
  logic [WAYS-1:0] w_s1_hit;
  logic          w_s1_miss;

  logic          r_s2_valid;
  logic [WAYS-1:0] r_s2_hit;
  addr_t         r_s2_addr;
  line_data_t    w_way_data [WAYS];
  line_data_t    w_s2_data;

  addr_t         r_miss_addr;
  set_idx_t      w_miss_idx;
  logic [1:0]    r_beat;
  logic          r_ar_done;      // drain only, AR of current word taken
  line_data_t    r_line;
  line_data_t    w_fill_data;
  logic          w_beat;
  logic          w_fill;
  logic [`ICACHE_SETS-1:0] r_repl;

  // ============================================================
  // S0: new request or replay of a finished refill
  // ============================================================
  assign o_req_ready = r_run && (r_state == IC_IDLE) && !w_s1_miss && o_line.ready;
  assign w_accept    = i_req_valid && o_req_ready;
  assign w_replay    = w_fill && (r_state == IC_DATA) && !i_flush;
  assign w_s0_valid  = w_accept || w_replay;
  assign w_s0_addr   = w_replay ? r_miss_addr : i_req_addr;

  assign w_clear = (i_fence_i || r_fence_pend) && (r_state == IC_IDLE);

  assign w_miss_idx  = r_miss_addr[OFF_W +: $bits(set_idx_t)];
  assign w_fill_data = {i_rdata, r_line[$bits(line_data_t)-33:0]};   // last beat goes on top

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    tag_t w_tag;
    logic w_tag_valid;

    icache_way way_i (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_clear     (w_clear),
      .i_rd_index  (w_s0_addr[OFF_W +: $bits(set_idx_t)]),
      .i_wr        (w_fill && (r_repl[w_miss_idx] == 1'(w))),
      .i_wr_index  (w_miss_idx),
      .i_wr_tag    (r_miss_addr[`ICACHE_ADDR_W-1 -: $bits(tag_t)]),
      .i_wr_data   (w_fill_data),
      .o_tag       (w_tag),
      .o_tag_valid (w_tag_valid),
      .o_data      (w_way_data[w])
    );

    assign w_s1_hit[w] = w_tag_valid && (w_tag == r_s1_addr[`ICACHE_ADDR_W-1 -: $bits(tag_t)]);
  end

  // ============================================================
  // S1 compare, S2 select and push
  // ============================================================
  assign w_s1_miss = r_s1_valid && !(|w_s1_hit) && !i_flush;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_hit   <= '0;
    end else begin
      r_s1_valid <= w_s0_valid;   // taken in the flush cycle, so it is post-flush
      r_s2_valid <= r_s1_valid && (|w_s1_hit) && !i_flush;
      r_s2_hit   <= w_s1_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_addr <= w_s0_addr;
    r_s2_addr <= r_s1_addr;
  end

  always_comb begin
    w_s2_data = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (r_s2_hit[w]) begin
        w_s2_data = w_s2_data | w_way_data[w];
      end
    end
  end

  assign o_line.valid = r_s2_valid && !i_flush;
  assign o_line.base  = r_s2_addr[`ICACHE_ADDR_W-1:OFF_W];
  assign o_line.start = r_s2_addr[OFF_W-1:2];
  assign o_line.data  = w_s2_data;

  // ============================================================
  // miss FSM and AXI4-Lite read master
  // ============================================================
  assign w_beat = i_rvalid && ((r_state == IC_DATA) || ((r_state == IC_DRAIN) && r_ar_done));
  assign w_fill = w_beat && (r_beat == 2'd3);

  assign o_arvalid = (r_state == IC_ADDR) || ((r_state == IC_DRAIN) && !r_ar_done);
  assign o_araddr  = {r_miss_addr[`ICACHE_ADDR_W-1:OFF_W], r_beat, 2'b00};
  assign o_rready  = 1'b1;
  assign o_arprot  = 3'b100;   // instruction, secure, unprivileged

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= IC_IDLE;
      r_run        <= 1'b0;
      r_beat       <= '0;
      r_ar_done    <= 1'b0;
      r_fence_pend <= 1'b0;
      r_repl       <= '0;
    end else begin
      r_run        <= 1'b1;
      r_fence_pend <= !w_clear && (r_fence_pend || i_fence_i);
      if (w_fill) begin
        r_repl[w_miss_idx] <= ~r_repl[w_miss_idx];
      end
      if (w_beat) begin
        r_beat <= r_beat + 2'd1;
      end
      case (r_state)
        IC_IDLE: begin
          if (w_s1_miss) begin
            r_state <= IC_ADDR;
            r_beat  <= '0;
          end
        end
        IC_ADDR: begin
          if (i_flush) begin
            r_state   <= IC_DRAIN;
            r_ar_done <= i_arready;
          end else if (i_arready) begin
            r_state <= IC_DATA;
          end
        end
        IC_DATA: begin
          if (w_fill) begin
            r_state <= IC_IDLE;
          end else if (i_flush) begin
            r_state   <= IC_DRAIN;
            r_ar_done <= !w_beat;   // flush while this word is still outstanding
          end else if (w_beat) begin
            r_state <= IC_ADDR;
          end
        end
        IC_DRAIN: begin
          if (!r_ar_done) begin
            r_ar_done <= i_arready;
          end else if (w_beat) begin
            r_ar_done <= 1'b0;
            if (w_fill) begin
              r_state <= IC_IDLE;
            end
          end
        end
        default: r_state <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == IC_IDLE) && w_s1_miss) begin
      r_miss_addr <= r_s1_addr;
    end
    if (w_beat) begin
      r_line[32*r_beat +: 32] <= i_rdata;
    end
  end

  a_hit_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_s1_valid |-> $onehot0(w_s1_hit));

  a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
// shared types for the fetch path; widths follow the settings header, 16-byte lines only
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // address without the byte offset within a line
  typedef logic [`ICACHE_ADDR_W-$clog2(`ICACHE_LINE_BYTES)-1:0] line_base_t;

  typedef logic [$clog2(`ICACHE_SETS)-1:0] set_idx_t;
  typedef logic [$bits(line_base_t)-$bits(set_idx_t)-1:0] tag_t;

  typedef logic [8*`ICACHE_LINE_BYTES-1:0] line_data_t;
  typedef logic [1:0] word_idx_t;   // word within the line

  typedef struct packed {
    line_base_t base;
    word_idx_t  start;  // first word the front end asked for
    line_data_t data;
  } fetch_line_t;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_ADDR,   // AR beat pending
    IC_DATA,   // waiting on R beat
    IC_DRAIN   // refill after a flush, no replay
  } icache_state_t;

endpackage

`default_nettype wire

// ==== src/icache_way.sv ====
// one cache way; tag read takes one cycle, data read lags it by one more, write wins on same index
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_way (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_clear,
  input  icache_pkg::set_idx_t   i_rd_index,
  input  logic                   i_wr,
  input  icache_pkg::set_idx_t   i_wr_index,
  input  icache_pkg::tag_t       i_wr_tag,
  input  icache_pkg::line_data_t i_wr_data,
  output icache_pkg::tag_t       o_tag,
  output logic                   o_tag_valid,
  output icache_pkg::line_data_t o_data
);
  import icache_pkg::*;

  tag_t                    r_tags [`ICACHE_SETS];
  line_data_t              r_lines [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0] r_valid;
  set_idx_t                r_s1_index;   // index seen by the tag read last cycle
  logic                    w_tag_fwd;
  logic                    w_data_fwd;

  assign w_tag_fwd  = i_wr && (i_wr_index == i_rd_index);
  assign w_data_fwd = i_wr && (i_wr_index == r_s1_index);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      o_tag_valid <= 1'b0;
    end else begin
      if (i_clear) begin
        r_valid <= '0;
      end else if (i_wr) begin
        r_valid[i_wr_index] <= 1'b1;
      end
      // a lookup in the fence cycle already sees the cleared tags
      o_tag_valid <= !i_clear && (w_tag_fwd || r_valid[i_rd_index]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tags[i_wr_index]  <= i_wr_tag;
      r_lines[i_wr_index] <= i_wr_data;
    end
    o_tag      <= w_tag_fwd ? i_wr_tag : r_tags[i_rd_index];
    r_s1_index <= i_rd_index;
    o_data     <= w_data_fwd ? i_wr_data : r_lines[r_s1_index];   // lands in S2
  end

endmodule

`default_nettype wire

// ==== src/inst_aligner.sv ====
// hands out 32-bit words of the head line from its start word up; no compressed instructions
`timescale 1ns/1ps
`default_nettype none

module inst_aligner (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush,
  fetch_line_if.sink        i_line,
  output logic              o_inst_valid,
  output logic [31:0]       o_inst,
  output icache_pkg::addr_t o_inst_addr,
  input  logic              i_inst_ready
);
  import icache_pkg::*;

  logic      r_in_line;   // head line partly consumed
  word_idx_t r_word;
  word_idx_t w_word;
  logic      w_fire;
  logic      w_last;

  assign w_word = r_in_line ? r_word : i_line.start;

  assign o_inst_valid = i_line.valid && !i_flush;
  assign o_inst       = i_line.data[32*w_word +: 32];
  assign o_inst_addr  = {i_line.base, w_word, 2'b00};

  assign w_fire = o_inst_valid && i_inst_ready;
  assign w_last = (w_word == 2'd3);

  assign i_line.ready = w_fire && w_last;   // pop with the last word

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_line <= 1'b0;
      r_word    <= '0;
    end else if (i_flush) begin
      r_in_line <= 1'b0;
    end else if (w_fire) begin
      r_in_line <= !w_last;
      r_word    <= w_word + 2'd1;
    end
  end

endmodule

`default_nettype wire
